// ==== verif/mem_patterns.txt ====
# Columns: op (W write, R read, S clock step), read port mask, address, data or expected data.
# Every line up to an S line is driven in the same cycle. All fields are hex.
R 1 00 00000000
R 2 45 00000000
R 4 8a 00000000
R 8 ff 00000000
S 0 00 00000000
R f 3c 00000000
S 0 00 00000000
W 0 12 a5a5f00d
S 0 00 00000000
R f 12 a5a5f00d
S 0 00 00000000
W 0 13 11112222
S 0 00 00000000
W 0 14 55556666
S 0 00 00000000
W 0 52 33334444
S 0 00 00000000
R 1 12 a5a5f00d
R 2 13 11112222
R 4 14 55556666
R 8 52 33334444
S 0 00 00000000
W 0 12 deadbeef
R 3 12 a5a5f00d
S 0 00 00000000
R 3 12 deadbeef
S 0 00 00000000
R 3 13 11112222
S 0 00 00000000
R c 14 55556666
S 0 00 00000000
R c 52 33334444
S 0 00 00000000

// ==== project.f ====
+incdir+verif
verilog/mem_geom_pkg.sv
verilog/sram_pkg.sv
verilog/sram_1r1w.sv
verilog/mem_init_seq.sv
verilog/wr_align.sv
verilog/rd_port_ctrl.sv
verilog/nr1w_dup_core.sv
verilog/mem_4r1w_top.sv
verif/tb_mem_4r1w.sv

// ==== verif/tb_check_tasks.svh ====
`ifndef TB_CHECK_TASKS_SVH
`define TB_CHECK_TASKS_SVH

task automatic check_val(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
  if (exp_v !== act_v)
    abort_run($sformatf("ERR %s expected %0h actual %0h", name, exp_v, act_v));
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] state);
  return state * 32'd1664525 + 32'd1013904223;
endfunction

// Counts the edges from reset release until ready is seen high.
task automatic wait_ready();
  int n;
  n = 0;
  while (ready !== 1'b1 && n < TIMEOUT)
  begin
    @(posedge clk);
    n++;
    @(negedge clk);
  end
  if (ready !== 1'b1)
    abort_run("ready never went high after reset was released");
  else
    check_val("ready latency", NUMSROW + 1, n);
endtask

task automatic wait_vld();
  int n;
  n = 0;
  while (reads_pending() && n < TIMEOUT)
  begin
    @(negedge clk);
    n++;
  end
  if (reads_pending())
    abort_run("some issued reads never produced an rd_vld pulse");
endtask

`endif

// ==== verif/tb_mem_4r1w.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_4r1w
  import mem_geom_pkg::*;
  import sram_pkg::*;
();

  localparam int WIDTH      = DEF_WIDTH;
  localparam int NUMADDR    = DEF_NUMADDR;
  localparam int NUMVBNK    = DEF_NUMVBNK;
  localparam int NUMRDPT    = DEF_NUMRDPT;
  localparam int NUMWRDS    = DEF_NUMWRDS;
  localparam int NUMSROW    = DEF_NUMSROW;
  localparam int SRAM_DELAY = DEF_SRAM_DELAY;
  localparam int BITADDR    = $clog2(NUMADDR);
  localparam int BITPADR    = $clog2(NUMVBNK) + $clog2(NUMSROW) + $clog2(NUMWRDS);
  localparam int TIMEOUT    = 1000;
  localparam int QDEPTH     = 8;

  logic                         clk;
  logic                         reset;
  logic                         write;
  logic [BITADDR-1:0]           wr_adr;
  logic [WIDTH-1:0]             din;
  logic [NUMRDPT-1:0]           read;
  logic [NUMRDPT*BITADDR-1:0]   rd_adr;
  wire                          ready;
  wire  [NUMRDPT-1:0]           rd_vld;
  wire  [NUMRDPT*WIDTH-1:0]     rd_dout;
  wire  [NUMRDPT*BITPADR-1:0]   rd_padr;

  logic [WIDTH-1:0]     sb [0:NUMADDR-1];
  logic [WIDTH-1:0]     q_data [0:NUMRDPT-1][0:QDEPTH-1];
  logic [BITPADR-1:0]   q_padr [0:NUMRDPT-1][0:QDEPTH-1];
  int                   q_due  [0:NUMRDPT-1][0:QDEPTH-1];
  int                   q_head [0:NUMRDPT-1];
  int                   q_tail [0:NUMRDPT-1];
  int                   cyc;
  logic [31:0]          seed;
  logic                 nxt_write;
  logic [BITADDR-1:0]   nxt_wadr;
  logic [WIDTH-1:0]     nxt_din;
  logic [NUMRDPT-1:0]   nxt_read;
  logic [BITADDR-1:0]   nxt_radr [0:NUMRDPT-1];
  logic [WIDTH-1:0]     nxt_exp  [0:NUMRDPT-1];

  mem_4r1w_top #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK), .NUMRDPT(NUMRDPT),
    .NUMWRDS(NUMWRDS), .PHYWDTH(WIDTH*NUMWRDS), .NUMSROW(NUMSROW), .SRAM_DELAY(SRAM_DELAY)
  ) mem_4r1w_top_i (
    .clk(clk), .reset(reset), .ready(ready),
    .write(write), .wr_adr(wr_adr), .din(din),
    .read(read), .rd_adr(rd_adr), .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_padr(rd_padr)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  // Bank, SRAM row and word slot packed top to bottom.
  function automatic logic [BITPADR-1:0] phys_addr_of(input int adr);
    int per_bank;
    int vrow;
    per_bank = NUMADDR / NUMVBNK;
    vrow = adr % per_bank;
    return BITPADR'((adr / per_bank) * NUMSROW * NUMWRDS + (vrow / NUMWRDS) * NUMWRDS
                    + vrow % NUMWRDS);
  endfunction

  function automatic logic reads_pending();
    logic busy;
    busy = 1'b0;
    for (int p = 0; p < NUMRDPT; p++)
      busy = busy | (q_head[p] != q_tail[p]);
    return busy;
  endfunction

  // Reads take their expected data before this cycle's write updates the scoreboard.
  task automatic apply_cycle();
    logic [NUMRDPT*BITADDR-1:0] adr_bus;
    adr_bus = '0;
    @(posedge clk);
    for (int p = 0; p < NUMRDPT; p++)
    begin
      adr_bus[p*BITADDR +: BITADDR] = nxt_radr[p];
      if (nxt_read[p])
      begin
        q_data[p][q_tail[p] % QDEPTH] = nxt_exp[p];
        q_padr[p][q_tail[p] % QDEPTH] = phys_addr_of(nxt_radr[p]);
        q_due[p][q_tail[p] % QDEPTH]  = cyc + SRAM_DELAY + 2;  // Drive edge, sample edge, pipe.
        q_tail[p]++;
      end
    end
    write  <= nxt_write;
    wr_adr <= nxt_wadr;
    din    <= nxt_din;
    read   <= nxt_read;
    rd_adr <= adr_bus;
    if (nxt_write)
      sb[nxt_wadr] = nxt_din;
    nxt_write = 1'b0;
    nxt_read  = '0;
  endtask

  task automatic run_patterns();
    int                   fd;
    int                   nf;
    string                line;
    byte                  op;
    logic [NUMRDPT-1:0]   mask;
    logic [BITADDR-1:0]   adr;
    logic [WIDTH-1:0]     data;
    fd = $fopen("verif/mem_patterns.txt", "r");
    if (fd == 0)
      abort_run("could not open the pattern file verif/mem_patterns.txt");
    while (!$feof(fd))
    begin
      line = "";
      void'($fgets(line, fd));
      nf = $sscanf(line, "%c %h %h %h", op, mask, adr, data);
      if (line.len() > 0 && line[0] != "#" && nf == 4)
      begin
        if (op == "W")
        begin
          nxt_write = 1'b1;
          nxt_wadr  = adr;
          nxt_din   = data;
        end
        else if (op == "R")
        begin
          for (int p = 0; p < NUMRDPT; p++)
          begin
            if (mask[p])
            begin
              nxt_read[p] = 1'b1;
              nxt_radr[p] = adr;
              nxt_exp[p]  = data;
            end
          end
        end
        else if (op == "S")
          apply_cycle();
        else
          abort_run("the pattern file holds an unknown operation");
      end
    end
    $fclose(fd);
  endtask

  task automatic run_random(input int count);
    logic [BITADDR-1:0] adr;
    for (int i = 0; i < count; i++)
    begin
      seed      = lcg_next(seed);
      nxt_write = seed[31];
      nxt_wadr  = BITADDR'(seed >> 16);
      seed      = lcg_next(seed);
      nxt_din   = WIDTH'(seed);
      seed      = lcg_next(seed);
      nxt_read  = NUMRDPT'(seed >> 28);
      for (int p = 0; p < NUMRDPT; p++)
      begin
        seed = lcg_next(seed);
        adr  = BITADDR'(seed >> 20);
        if (nxt_write && adr == nxt_wadr)
          adr = adr ^ 1;  // Keeps the read off the address being written.
        nxt_radr[p] = adr;
        nxt_exp[p]  = sb[adr];
      end
      apply_cycle();
    end
  endtask

  // Every returned read is matched against the oldest outstanding one on its port.
  always @(negedge clk)
  begin
    for (int p = 0; p < NUMRDPT; p++)
    begin
      if (rd_vld[p] === 1'b1)
      begin
        if (q_head[p] == q_tail[p])
          abort_run($sformatf("port %0d raised rd_vld without an issued read", p));
        else
        begin
          check_val($sformatf("rd_vld latency port %0d", p), q_due[p][q_head[p] % QDEPTH], cyc);
          check_val($sformatf("rd_dout port %0d", p), q_data[p][q_head[p] % QDEPTH],
                    rd_dout[p*WIDTH +: WIDTH]);
          check_val($sformatf("rd_padr port %0d", p), q_padr[p][q_head[p] % QDEPTH],
                    rd_padr[p*BITPADR +: BITPADR]);
          q_head[p]++;
        end
      end
    end
  end

  initial
  begin
    clk       = 1'b0;
    reset     = 1'b1;
    write     = 1'b0;
    wr_adr    = '0;
    din       = '0;
    read      = '0;
    rd_adr    = '0;
    cyc       = 0;
    seed      = 32'd37612;
    nxt_write = 1'b0;
    nxt_wadr  = '0;
    nxt_din   = '0;
    nxt_read  = '0;
    for (int p = 0; p < NUMRDPT; p++)
    begin
      q_head[p]   = 0;
      q_tail[p]   = 0;
      nxt_radr[p] = '0;
      nxt_exp[p]  = '0;
    end
    for (int a = 0; a < NUMADDR; a++)
      sb[a] = '0;  // The init sweep clears every word.
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_val("ready during reset", 0, ready);
    check_val("rd_vld during reset", 0, rd_vld);
    @(posedge clk);
    reset <= 1'b0;
    wait_ready();
    run_patterns();
    run_random(200);
    apply_cycle();
    wait_vld();
    $display("all tests passed");
    $finish;
  end

`include "tb_check_tasks.svh"

endmodule

`default_nettype wire

// ==== verilog/mem_4r1w_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_4r1w_top
  import mem_geom_pkg::*;
  import sram_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMADDR    = DEF_NUMADDR,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int NUMRDPT    = DEF_NUMRDPT,
  parameter int NUMWRDS    = DEF_NUMWRDS,
  parameter int PHYWDTH    = DEF_PHYWDTH,
  parameter int NUMSROW    = DEF_NUMSROW,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  localparam int BITADDR   = $clog2(NUMADDR),
  localparam int BITVBNK   = $clog2(NUMVBNK),
  localparam int BITSROW   = $clog2(NUMSROW),
  localparam int BITWRDS   = $clog2(NUMWRDS),
  localparam int BITPADR   = BITVBNK + BITSROW + BITWRDS
)
(
  input  wire                         clk,
  input  wire                         reset,
  output wire                         ready,
  input  wire                         write,
  input  wire [BITADDR-1:0]           wr_adr,
  input  wire [WIDTH-1:0]             din,
  input  wire [NUMRDPT-1:0]           read,
  input  wire [NUMRDPT*BITADDR-1:0]   rd_adr,
  output wire [NUMRDPT-1:0]           rd_vld,
  output wire [NUMRDPT*WIDTH-1:0]     rd_dout,
  output wire [NUMRDPT*BITPADR-1:0]   rd_padr
);

  logic                                 reset_q;
  logic                                 reset_int;
  wire  [NUMRDPT*NUMVBNK-1:0]           t1_write;
  wire  [NUMRDPT*NUMVBNK*BITSROW-1:0]   t1_wr_row;
  wire  [NUMRDPT*NUMVBNK*PHYWDTH-1:0]   t1_din;
  wire  [NUMRDPT*NUMVBNK*PHYWDTH-1:0]   t1_bw;
  wire  [NUMRDPT*NUMVBNK-1:0]           t1_read;
  wire  [NUMRDPT*NUMVBNK*BITSROW-1:0]   t1_rd_row;
  wire  [NUMRDPT*NUMVBNK*PHYWDTH-1:0]   t1_dout;

  always_ff @(posedge clk)
  begin
    reset_q <= reset;
  end

  assign reset_int = reset_q & reset;  // Asserts a cycle late, releases with reset.

  nr1w_dup_core #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK), .NUMRDPT(NUMRDPT),
    .NUMWRDS(NUMWRDS), .PHYWDTH(PHYWDTH), .NUMSROW(NUMSROW), .SRAM_DELAY(SRAM_DELAY)
  ) nr1w_dup_core_i (
    .clk(clk), .reset(reset_int), .ready(ready),
    .write(write), .wr_adr(wr_adr), .din(din),
    .read(read), .rd_adr(rd_adr), .rd_vld(rd_vld), .rd_dout(rd_dout), .rd_padr(rd_padr),
    .t1_write(t1_write), .t1_wr_row(t1_wr_row), .t1_din(t1_din), .t1_bw(t1_bw),
    .t1_read(t1_read), .t1_rd_row(t1_rd_row), .t1_dout(t1_dout)
  );

  for (genvar p = 0; p < NUMRDPT; p++)
  begin : g_copy
    for (genvar b = 0; b < NUMVBNK; b++)
    begin : g_bank
      localparam int IDX = p * NUMVBNK + b;  // Copy p owns banks p*NUMVBNK and up.

      sram_1r1w #(
        .PHYWDTH(PHYWDTH), .NUMSROW(NUMSROW), .SRAM_DELAY(SRAM_DELAY)
      ) sram_1r1w_i (
        .clk(clk),
        .write(t1_write[IDX]),
        .wr_row(t1_wr_row[IDX*BITSROW +: BITSROW]),
        .din(t1_din[IDX*PHYWDTH +: PHYWDTH]),
        .bw(t1_bw[IDX*PHYWDTH +: PHYWDTH]),
        .read(t1_read[IDX]),
        .rd_row(t1_rd_row[IDX*BITSROW +: BITSROW]),
        .dout(t1_dout[IDX*PHYWDTH +: PHYWDTH])
      );
    end
  end

endmodule

`default_nettype wire

// ==== verilog/nr1w_dup_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module nr1w_dup_core
  import mem_geom_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMADDR    = DEF_NUMADDR,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int NUMRDPT    = DEF_NUMRDPT,
  parameter int NUMWRDS,
  parameter int PHYWDTH,
  parameter int NUMSROW,
  parameter int SRAM_DELAY,
  localparam int BITADDR   = $clog2(NUMADDR),
  localparam int BITVBNK   = $clog2(NUMVBNK),
  localparam int BITSROW   = $clog2(NUMSROW),
  localparam int BITWRDS   = $clog2(NUMWRDS),
  localparam int BITPADR   = BITVBNK + BITSROW + BITWRDS
)
(
  input  wire                                 clk,
  input  wire                                 reset,
  output wire                                 ready,
  input  wire                                 write,
  input  wire [BITADDR-1:0]                   wr_adr,
  input  wire [WIDTH-1:0]                     din,
  input  wire [NUMRDPT-1:0]                   read,
  input  wire [NUMRDPT*BITADDR-1:0]           rd_adr,
  output wire [NUMRDPT-1:0]                   rd_vld,
  output wire [NUMRDPT*WIDTH-1:0]             rd_dout,
  output wire [NUMRDPT*BITPADR-1:0]           rd_padr,
  output wire [NUMRDPT*NUMVBNK-1:0]           t1_write,
  output wire [NUMRDPT*NUMVBNK*BITSROW-1:0]   t1_wr_row,
  output wire [NUMRDPT*NUMVBNK*PHYWDTH-1:0]   t1_din,
  output wire [NUMRDPT*NUMVBNK*PHYWDTH-1:0]   t1_bw,
  output wire [NUMRDPT*NUMVBNK-1:0]           t1_read,
  output wire [NUMRDPT*NUMVBNK*BITSROW-1:0]   t1_rd_row,
  input  wire [NUMRDPT*NUMVBNK*PHYWDTH-1:0]   t1_dout
);

  logic                 init_wr;
  logic [BITSROW-1:0]   init_row;
  logic                 write_q;
  logic [BITADDR-1:0]   wr_adr_q;
  logic [WIDTH-1:0]     din_q;
  logic [NUMVBNK-1:0]   bank_we;
  logic [BITSROW-1:0]   wr_row;
  logic [PHYWDTH-1:0]   wr_data;
  logic [PHYWDTH-1:0]   wr_bw;
  logic [NUMRDPT-1:0]   read_ok;

  // The write lands in the SRAM on the same edge that a same-cycle read samples it.
  always_ff @(posedge clk)
  begin
    if (reset)
      write_q <= 1'b0;
    else
      write_q <= write & ready;
  end

  always_ff @(posedge clk)
  begin
    if (write)
    begin
      wr_adr_q <= wr_adr;
      din_q    <= din;
    end
  end

  assign read_ok = read & {NUMRDPT{ready}};

  mem_init_seq #(.NUMSROW(NUMSROW)) mem_init_seq_i (
    .clk(clk), .reset(reset), .init_wr(init_wr), .init_row(init_row), .ready(ready)
  );

  wr_align #(
    .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK),
    .NUMWRDS(NUMWRDS), .PHYWDTH(PHYWDTH), .NUMSROW(NUMSROW)
  ) wr_align_i (
    .write(write_q), .wr_adr(wr_adr_q), .din(din_q), .init_wr(init_wr), .init_row(init_row),
    .bank_we(bank_we), .wr_row(wr_row), .wr_data(wr_data), .wr_bw(wr_bw)
  );

  assign t1_write  = {NUMRDPT{bank_we}};  // Every copy sees the same write.
  assign t1_wr_row = {(NUMRDPT*NUMVBNK){wr_row}};
  assign t1_din    = {(NUMRDPT*NUMVBNK){wr_data}};
  assign t1_bw     = {(NUMRDPT*NUMVBNK){wr_bw}};

  for (genvar p = 0; p < NUMRDPT; p++)
  begin : g_port
    logic [BITSROW-1:0] rd_row;

    rd_port_ctrl #(
      .WIDTH(WIDTH), .NUMADDR(NUMADDR), .NUMVBNK(NUMVBNK), .NUMWRDS(NUMWRDS),
      .PHYWDTH(PHYWDTH), .NUMSROW(NUMSROW), .SRAM_DELAY(SRAM_DELAY)
    ) rd_port_ctrl_i (
      .clk(clk), .reset(reset),
      .read(read_ok[p]), .rd_adr(rd_adr[p*BITADDR +: BITADDR]),
      .bank_re(t1_read[p*NUMVBNK +: NUMVBNK]), .rd_row(rd_row),
      .bank_dout(t1_dout[p*NUMVBNK*PHYWDTH +: NUMVBNK*PHYWDTH]),
      .rd_vld(rd_vld[p]), .rd_dout(rd_dout[p*WIDTH +: WIDTH]),
      .rd_padr(rd_padr[p*BITPADR +: BITPADR])
    );

    assign t1_rd_row[p*NUMVBNK*BITSROW +: NUMVBNK*BITSROW] = {NUMVBNK{rd_row}};
  end

endmodule

`default_nettype wire

// ==== verilog/rd_port_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module rd_port_ctrl
  import mem_geom_pkg::*;
  import sram_pkg::*;
#(
  parameter int WIDTH      = DEF_WIDTH,
  parameter int NUMADDR    = DEF_NUMADDR,
  parameter int NUMVBNK    = DEF_NUMVBNK,
  parameter int NUMWRDS    = DEF_NUMWRDS,
  parameter int PHYWDTH    = DEF_PHYWDTH,
  parameter int NUMSROW    = DEF_NUMSROW,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  localparam int BITADDR   = $clog2(NUMADDR),
  localparam int BITVBNK   = $clog2(NUMVBNK),
  localparam int BITSROW   = $clog2(NUMSROW),
  localparam int BITWRDS   = $clog2(NUMWRDS),
  localparam int BITPADR   = BITVBNK + BITSROW + BITWRDS
)
(
  input  wire                         clk,
  input  wire                         reset,
  input  wire                         read,
  input  wire [BITADDR-1:0]           rd_adr,
  output logic [NUMVBNK-1:0]          bank_re,
  output wire  [BITSROW-1:0]          rd_row,
  input  wire [NUMVBNK*PHYWDTH-1:0]   bank_dout,
  output wire                         rd_vld,
  output wire  [WIDTH-1:0]            rd_dout,
  output wire  [BITPADR-1:0]          rd_padr
);

  logic [BITPADR-1:0]   padr_in;
  logic [SRAM_DELAY:0]  vld_pipe;
  logic [BITPADR-1:0]   padr_pipe [0:SRAM_DELAY];
  logic [BITVBNK-1:0]   sel_bank;
  logic [BITWRDS-1:0]   sel_word;
  logic [PHYWDTH-1:0]   sel_row;

  // Physical address is bank, SRAM row and word slot, top to bottom.
  assign padr_in = {BITVBNK'(bank_of(32'(rd_adr), BITADDR, BITVBNK)),
                    BITSROW'(srow_of(32'(rd_adr), BITADDR, BITVBNK, BITWRDS)),
                    BITWRDS'(word_of(32'(rd_adr), BITADDR, BITVBNK, BITWRDS))};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      vld_pipe <= '0;
    end
    else
    begin
      vld_pipe[0] <= read;
      for (int i = 1; i <= SRAM_DELAY; i++)
      begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    padr_pipe[0] <= padr_in;  // Stage 0 is the address register.
    for (int i = 1; i <= SRAM_DELAY; i++)
    begin
      padr_pipe[i] <= padr_pipe[i-1];
    end
  end

  always_comb
  begin
    for (int b = 0; b < NUMVBNK; b++)
    begin
      bank_re[b] = vld_pipe[0] && (padr_pipe[0][BITPADR-1 -: BITVBNK] == BITVBNK'(b));
    end
  end

  assign rd_row = padr_pipe[0][BITWRDS +: BITSROW];

  // The last stage lines up with the SRAM output.
  assign sel_bank = padr_pipe[SRAM_DELAY][BITPADR-1 -: BITVBNK];
  assign sel_word = padr_pipe[SRAM_DELAY][BITWRDS-1:0];
  assign sel_row  = bank_dout[sel_bank*PHYWDTH +: PHYWDTH];

  assign rd_vld  = vld_pipe[SRAM_DELAY];
  assign rd_dout = sel_row[sel_word*WIDTH +: WIDTH];
  assign rd_padr = padr_pipe[SRAM_DELAY];

endmodule

`default_nettype wire

// ==== verilog/wr_align.sv ====
`timescale 1ns/100ps
`default_nettype none

module wr_align
  import mem_geom_pkg::*;
  import sram_pkg::*;
#(
  parameter int WIDTH    = DEF_WIDTH,
  parameter int NUMADDR  = DEF_NUMADDR,
  parameter int NUMVBNK  = DEF_NUMVBNK,
  parameter int NUMWRDS  = DEF_NUMWRDS,
  parameter int PHYWDTH  = DEF_PHYWDTH,
  parameter int NUMSROW  = DEF_NUMSROW,
  localparam int BITADDR = $clog2(NUMADDR),
  localparam int BITVBNK = $clog2(NUMVBNK),
  localparam int BITSROW = $clog2(NUMSROW),
  localparam int BITWRDS = $clog2(NUMWRDS)
)
(
  input  wire                 write,
  input  wire [BITADDR-1:0]   wr_adr,
  input  wire [WIDTH-1:0]     din,
  input  wire                 init_wr,
  input  wire [BITSROW-1:0]   init_row,
  output logic [NUMVBNK-1:0]  bank_we,
  output logic [BITSROW-1:0]  wr_row,
  output logic [PHYWDTH-1:0]  wr_data,
  output logic [PHYWDTH-1:0]  wr_bw
);

  logic [BITVBNK-1:0] bank;
  logic [BITSROW-1:0] srow;
  logic [BITWRDS-1:0] word;

  assign bank = BITVBNK'(bank_of(32'(wr_adr), BITADDR, BITVBNK));
  assign srow = BITSROW'(srow_of(32'(wr_adr), BITADDR, BITVBNK, BITWRDS));
  assign word = BITWRDS'(word_of(32'(wr_adr), BITADDR, BITVBNK, BITWRDS));

  always_comb
  begin
    bank_we = '0;
    wr_row  = srow;
    wr_data = PHYWDTH'(din) << (word * WIDTH);  // Only the addressed slot is written.
    wr_bw   = PHYWDTH'({WIDTH{1'b1}}) << (word * WIDTH);
    if (init_wr)
    begin
      bank_we = '1;
      wr_row  = init_row;
      wr_data = '0;
      wr_bw   = '1;
    end
    else if (write)
    begin
      bank_we[bank] = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mem_init_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_init_seq
  import sram_pkg::*;
#(
  parameter int NUMSROW  = DEF_NUMSROW,
  localparam int BITSROW = $clog2(NUMSROW)
)
(
  input  wire                 clk,
  input  wire                 reset,
  output wire                 init_wr,
  output logic [BITSROW-1:0]  init_row,
  output logic                ready
);

  logic busy;

  // One idle cycle to start, then one row per cycle, then ready.
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy     <= 1'b0;
      init_row <= '0;
      ready    <= 1'b0;
    end
    else if (busy)
    begin
      init_row <= init_row + 1'b1;
      if (init_row == BITSROW'(NUMSROW - 1))
      begin
        busy  <= 1'b0;
        ready <= 1'b1;  // Stays high until the next reset.
      end
    end
    else if (!ready)
    begin
      busy <= 1'b1;
    end
  end

  assign init_wr = busy;

endmodule

`default_nettype wire

// ==== verilog/sram_1r1w.sv ====
`timescale 1ns/100ps
`default_nettype none

module sram_1r1w
  import sram_pkg::*;
#(
  parameter int PHYWDTH    = DEF_PHYWDTH,
  parameter int NUMSROW    = DEF_NUMSROW,
  parameter int SRAM_DELAY = DEF_SRAM_DELAY,
  localparam int BITSROW   = $clog2(NUMSROW)
)
(
  input  wire                 clk,
  input  wire                 write,
  input  wire [BITSROW-1:0]   wr_row,
  input  wire [PHYWDTH-1:0]   din,
  input  wire [PHYWDTH-1:0]   bw,
  input  wire                 read,
  input  wire [BITSROW-1:0]   rd_row,
  output wire [PHYWDTH-1:0]   dout
);

  logic [PHYWDTH-1:0] mem     [0:NUMSROW-1];
  logic [PHYWDTH-1:0] rd_pipe [0:SRAM_DELAY-1];

  always_ff @(posedge clk)
  begin
    if (write)
      mem[wr_row] <= (mem[wr_row] & ~bw) | (din & bw);  // Per-bit masked write.
  end

  // A read and a write to the same row on one edge return the old row.
  always_ff @(posedge clk)
  begin
    if (read)
      rd_pipe[0] <= mem[rd_row];
    for (int i = 1; i < SRAM_DELAY; i++)
    begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[SRAM_DELAY-1];

endmodule

`default_nettype wire

// ==== verilog/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

  // Two logical words share one physical row.
  localparam int DEF_NUMWRDS = 2;

  localparam int DEF_PHYWDTH = 64;     // Word width times words per row.

  localparam int DEF_SRAM_DELAY = 1;   // Cycles from sampled read to data out.

  localparam int DEF_NUMSROW = 32;

endpackage

`default_nettype wire

// ==== verilog/mem_geom_pkg.sv ====
`default_nettype none

package mem_geom_pkg;

  localparam int DEF_WIDTH   = 32;
  localparam int DEF_NUMADDR = 256;
  localparam int DEF_NUMVBNK = 4;
  localparam int DEF_NUMRDPT = 4;

  // Bank select is taken from the top address bits.
  function automatic logic [31:0] bank_of(input logic [31:0] adr, input int bitaddr,
                                          input int bitvbnk);
    return adr >> (bitaddr - bitvbnk);
  endfunction

  function automatic logic [31:0] vrow_of(input logic [31:0] adr, input int bitaddr,
                                          input int bitvbnk);
    return adr & ((32'd1 << (bitaddr - bitvbnk)) - 32'd1);
  endfunction

  function automatic logic [31:0] word_of(input logic [31:0] adr, input int bitaddr,
                                          input int bitvbnk, input int bitwrds);
    return vrow_of(adr, bitaddr, bitvbnk) & ((32'd1 << bitwrds) - 32'd1);
  endfunction

  function automatic logic [31:0] srow_of(input logic [31:0] adr, input int bitaddr,
                                          input int bitvbnk, input int bitwrds);
    return vrow_of(adr, bitaddr, bitvbnk) >> bitwrds;  // Word slot bits are dropped.
  endfunction

endpackage

`default_nettype wire
